//--- verilog.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_if.sv
logic/sync_fifo.sv
logic/fetch_buffer.sv
logic/predecode.sv
logic/pc_sequencer.sv
logic/fetch_unit.sv
verification/icache_responder.sv
verification/fetch_unit_tb.sv

//--- Makefile
BIN     := obj_dir/Vfetch_unit_tb
SOURCES := $(filter-out +%,$(shell cat verilog.f)) logic/fetch_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): verilog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module fetch_unit_tb -Mdir obj_dir

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

//--- verification/fetch_unit_tb.sv
`include "fetch_settings.svh"

module fetch_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PACKETS = 2000;
  localparam int MAX_CYCLES  = NUM_PACKETS * 40;

  logic         clk;
  logic         rst_n;
  logic         ar_ready;
  logic         ar_valid;
  logic [31:0]  ar_addr;
  logic         r_valid;
  logic [127:0] r_data;
  logic         r_ready;
  logic         out_ready;
  logic         out_valid;
  logic [31:0]  out_pc;
  logic [31:0]  out_inst;
  logic         resp_err;

  integer       seed;
  integer       ready_rnd;
  logic [31:0]  model_pc;
  int           checked;
  int           cycles;

  fetch_unit dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .ar_ready_i  (ar_ready),
    .ar_valid_o  (ar_valid),
    .ar_addr_o   (ar_addr),
    .r_valid_i   (r_valid),
    .r_data_i    (r_data),
    .r_ready_o   (r_ready),
    .out_ready_i (out_ready),
    .out_valid_o (out_valid),
    .out_pc_o    (out_pc),
    .out_inst_o  (out_inst)
  );

  icache_responder #(
    .SEED (32'h45de0995)
  ) u_responder (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_ready_i  (r_ready),
    .error_o    (resp_err)
  );

  // ============================================================
  // reference program built with the responder's address rule
  // ============================================================

  function automatic logic is_jal_site(input logic [31:0] addr);
    logic [31:0] h;
    h = {2'b00, addr[31:2]} * 32'h9e37_79b1;
    return (h[31:29] == 3'd0) || (addr[11:2] == 10'h3ff);
  endfunction

  function automatic int jump_words(input logic [31:0] addr);
    logic [31:0] h;
    int          off;
    int          idx;
    h   = {2'b00, addr[31:2]} * 32'h9e37_79b1;
    idx = int'(addr[11:2]);
    off = int'(h[22:16]) - 64;
    if (off == 0) begin
      off = 1;
    end
    if ((idx + off < 0) || (idx + off > 1023)) begin
      off = -off;
    end
    return off;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [20:0] imm;
    if (is_jal_site(addr)) begin
      imm = 21'(jump_words(addr) * 4);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    end
    return {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
  endfunction

  function automatic logic [31:0] next_model_pc(input logic [31:0] pc);
    if (is_jal_site(pc)) begin
      return pc + 32'(jump_words(pc) * 4);
    end
    return pc + 32'd4;
  endfunction

  task automatic stop_failed(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_failed("value mismatch on the output");
    end
  endtask

  // ============================================================
  // clock and back-pressure
  // ============================================================

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  // core side ready about 70% of the time
  always @(posedge clk) begin
    ready_rnd = $random(seed);
    out_ready <= !rst_n && ($unsigned(ready_rnd) % 10 < 7);
  end

  // outputs are stable at the falling edge and a pop lands on the next rise
  always @(negedge clk) begin
    if (resp_err) begin
      stop_failed("the cache responder saw a broken AR/R handshake");
    end
    if (!rst_n && out_valid && out_ready) begin
      check_value("out_pc_o", out_pc, model_pc);
      check_value("out_inst_o", out_inst, word_at(model_pc));
      model_pc = next_model_pc(model_pc);
      checked++;
    end
  end

  initial begin
    seed      = 32'h45de0995;
    rst_n     = 1'b1;
    out_ready = 1'b0;
    model_pc  = `FETCH_RESET_PC;
    checked   = 0;
    cycles    = 0;

    repeat (7) @(posedge clk);
    @(negedge clk);
    check_value("ar_valid_o", 32'(ar_valid), 32'd0);
    check_value("r_ready_o", 32'(r_ready), 32'd0);
    check_value("out_valid_o", 32'(out_valid), 32'd0);
    @(posedge clk);
    rst_n <= 1'b0;

    while ((checked < NUM_PACKETS) && (cycles < MAX_CYCLES)) begin
      @(posedge clk);
      cycles++;
    end

    if (checked >= NUM_PACKETS) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("timeout: %0d of %0d packets after %0d cycles", checked, NUM_PACKETS, cycles);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  end

endmodule

//--- verification/icache_responder.sv
module icache_responder #(
  parameter logic [31:0] SEED = 32'h45de0995
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         ar_valid_i,
  input  logic [31:0]  ar_addr_i,
  output logic         ar_ready_o,
  output logic         r_valid_o,
  output logic [127:0] r_data_o,
  input  logic         r_ready_i,
  output logic         error_o
);

  timeunit 1ns;
  timeprecision 1ps;

  integer      seed;
  integer      rnd;
  logic        pending;
  logic [31:0] line_addr;
  int          delay;
  logic        ar_waiting;
  logic [31:0] held_addr;

  // ============================================================
  // memory contents, a pure function of the address
  // ============================================================

  function automatic logic is_jal_site(input logic [31:0] addr);
    logic [31:0] h;
    h = {2'b00, addr[31:2]} * 32'h9e37_79b1;
    // last word of each 4 KB region always jumps back
    return (h[31:29] == 3'd0) || (addr[11:2] == 10'h3ff);
  endfunction

  function automatic int jump_words(input logic [31:0] addr);
    logic [31:0] h;
    int          off;
    int          idx;
    h   = {2'b00, addr[31:2]} * 32'h9e37_79b1;
    idx = int'(addr[11:2]);
    off = int'(h[22:16]) - 64;
    if (off == 0) begin
      off = 1;
    end
    // stay inside the region
    if ((idx + off < 0) || (idx + off > 1023)) begin
      off = -off;
    end
    return off;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [20:0] imm;
    if (is_jal_site(addr)) begin
      imm = 21'(jump_words(addr) * 4);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    end
    // addi x1, x0, word index
    return {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
  endfunction

  function automatic logic [127:0] line_at(input logic [31:0] base);
    logic [127:0] line;
    int           n;
    for (n = 0; n < 4; n++) begin
      line[32*n +: 32] = word_at(base + 32'(4 * n));
    end
    return line;
  endfunction

  // ============================================================
  // AR/R handshake with random timing
  // ============================================================

  initial begin
    seed       = SEED;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    error_o    = 1'b0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      pending    <= 1'b0;
      delay      <= 0;
      ar_waiting <= 1'b0;
      error_o    <= 1'b0;
    end else begin
      rnd = $random(seed);
      ar_ready_o <= rnd[0];

      // a waiting request must keep valid and address
      if (ar_waiting && (!ar_valid_i || (ar_addr_i != held_addr))) begin
        $display("icache_responder: AR request changed while waiting (addr %h, was %h)",
                 ar_addr_i, held_addr);
        error_o <= 1'b1;
      end
      ar_waiting <= ar_valid_i && !ar_ready_o;
      held_addr  <= ar_addr_i;

      if (ar_valid_i && ar_ready_o) begin
        if (pending) begin
          $display("icache_responder: new AR request while a response is still pending");
          error_o <= 1'b1;
        end
        pending   <= 1'b1;
        line_addr <= {ar_addr_i[31:4], 4'b0000};
        delay     <= int'($unsigned(rnd[15:8]) % 6);
      end else if (pending && !r_valid_o) begin
        if (delay == 0) begin
          r_valid_o <= 1'b1;
          r_data_o  <= line_at(line_addr);
        end else begin
          delay <= delay - 1;
        end
      end else if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        pending   <= 1'b0;
      end
    end
  end

endmodule

//--- logic/fetch_unit.sv
`include "fetch_settings.svh"

module fetch_unit (
  input  logic         clk,
  input  logic         rst_n,
  // AR channel
  input  logic         ar_ready_i,
  output logic         ar_valid_o,
  output logic [31:0]  ar_addr_o,
  // R channel
  input  logic         r_valid_i,
  input  logic [127:0] r_data_i,
  output logic         r_ready_o,
  // core side
  input  logic         out_ready_i,
  output logic         out_valid_o,
  output logic [31:0]  out_pc_o,
  output logic [31:0]  out_inst_o
);

  import fetch_pkg::*;

  fetch_if fetch_bus ();

  logic        is_jal;
  logic [31:0] jal_target;
  logic        accept;
  logic        queue_full;
  logic        queue_empty;
  fetch_pkt_t  accept_pkt;
  fetch_pkt_t  head_pkt;

  // ============================================================
  // fetch path
  // ============================================================

  fetch_buffer u_fetch_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch      (fetch_bus),
    .ar_ready_i (ar_ready_i),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_ready_o  (r_ready_o)
  );

  predecode u_predecode (
    .pc_i     (fetch_bus.pc),
    .inst_i   (fetch_bus.inst),
    .class_o  (),
    .is_jal_o (is_jal),
    .target_o (jal_target)
  );

  pc_sequencer u_pc_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch        (fetch_bus),
    .is_jal_i     (is_jal),
    .target_i     (jal_target),
    .queue_full_i (queue_full),
    .accept_o     (accept),
    .pkt_o        (accept_pkt)
  );

  // ============================================================
  // output queue
  // ============================================================

  sync_fifo #(
    .entry_t (fetch_pkt_t),
    .DEPTH   (`FETCH_QUEUE_DEPTH)
  ) out_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (1'b0),
    .push_i  (accept),
    .data_i  (accept_pkt),
    .pop_i   (out_valid_o && out_ready_i),
    .data_o  (head_pkt),
    .empty_o (queue_empty),
    .full_o  (queue_full)
  );

  assign out_valid_o = !queue_empty;
  assign out_pc_o    = head_pkt.pc;
  assign out_inst_o  = head_pkt.inst;

endmodule

//--- logic/pc_sequencer.sv
`include "fetch_settings.svh"

module pc_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  fetch_if.seq                  fetch,
  input  logic                  is_jal_i,
  input  logic [31:0]           target_i,
  input  logic                  queue_full_i,
  output logic                  accept_o,
  output fetch_pkg::fetch_pkt_t pkt_o
);

  logic [31:0] pc_q;
  logic        flush_q;
  logic [31:0] next_pc;

  // take the word when it is there, not redirecting and queue has room
  assign accept_o = fetch.inst_valid && !flush_q && !queue_full_i;

  assign next_pc = is_jal_i ? target_i : pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q    <= `FETCH_RESET_PC;
      flush_q <= 1'b0;
    end else if (accept_o) begin
      pc_q    <= next_pc;
      // redirect pulse goes out with the target
      flush_q <= is_jal_i;
    end else begin
      flush_q <= 1'b0;
    end
  end

  assign fetch.pc    = pc_q;
  assign fetch.flush = flush_q;

  assign pkt_o.pc   = pc_q;
  assign pkt_o.inst = fetch.inst;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst_n)
    accept_o |=> pc_q[1:0] == 2'b00)
    else $error("pc_sequencer: next pc not word aligned");

endmodule

//--- logic/predecode.sv
module predecode (
  input  logic [31:0]            pc_i,
  input  logic [31:0]            inst_i,
  output fetch_pkg::inst_class_e class_o,
  output logic                   is_jal_o,
  output logic [31:0]            target_o
);

  import fetch_pkg::*;

  localparam logic [6:0] OPC_JAL = 7'b1101111;

  logic [6:0]  opcode;
  logic [31:0] j_imm;

  assign opcode = inst_i[6:0];

  // J-type immediate, imm[20|10:1|11|19:12], sign extended
  assign j_imm = {
    {12{inst_i[31]}},
    inst_i[19:12],
    inst_i[20],
    inst_i[30:21],
    1'b0
  };

  always_comb begin
    if (opcode == OPC_JAL) begin
      class_o = CLASS_JAL;
    end else begin
      class_o = CLASS_SEQ;
    end
  end

  assign is_jal_o = (class_o == CLASS_JAL);

  // pc relative, computed for every word
  assign target_o = pc_i + j_imm;

endmodule

//--- logic/fetch_buffer.sv
`include "fetch_settings.svh"

module fetch_buffer (
  input  logic             clk,
  input  logic             rst_n,
  fetch_if.buffer          fetch,
  input  logic             ar_ready_i,
  output logic             ar_valid_o,
  output logic [31:0]      ar_addr_o,
  input  logic             r_valid_i,
  input  fetch_pkg::line_t r_data_i,
  output logic             r_ready_o
);

  import fetch_pkg::*;

  localparam int LINE_AW = 32 - FETCH_LINE_OFFSET_BITS;
  localparam int CNT_W   = $clog2(`FETCH_LINE_DEPTH) + 1;

  localparam logic [31:0]        RESET_PC   = `FETCH_RESET_PC;
  localparam logic [CNT_W-1:0]   LINE_DEPTH = CNT_W'(`FETCH_LINE_DEPTH);

  typedef enum logic {
    IDLE,
    WAIT_DATA
  } rd_state_e;

  rd_state_e          state;
  logic [LINE_AW-1:0] head_addr;
  logic [CNT_W-1:0]   line_cnt;
  logic [LINE_AW-1:0] req_addr;
  logic               stale;
  logic [LINE_AW-1:0] pc_line;
  logic               busy;
  logic               issue;
  logic               resp_done;
  logic               push;
  logic               pop;
  logic               empty;
  line_t              head_line;

  // ============================================================
  // line bookkeeping
  // ============================================================

  assign pc_line = fetch.pc[31:FETCH_LINE_OFFSET_BITS];

  // pc has moved on to the next line, retire the head
  assign pop = !empty && (pc_line != head_addr) && !fetch.flush;

  // head_addr is the line at the fifo head; line_cnt counts lines
  // stored plus the one requested, so head_addr + line_cnt is next
  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_addr <= RESET_PC[31:FETCH_LINE_OFFSET_BITS];
      line_cnt  <= '0;
    end else if (fetch.flush) begin
      head_addr <= pc_line;
      line_cnt  <= CNT_W'(issue);
    end else begin
      if (pop) begin
        head_addr <= head_addr + 1'b1;
      end
      line_cnt <= line_cnt + CNT_W'(issue) - CNT_W'(pop);
    end
  end

  // ============================================================
  // AR/R read machine
  // ============================================================

  assign busy      = ar_valid_o || (state == WAIT_DATA);
  assign resp_done = r_valid_i && r_ready_o;

  // one request at a time, prefetch while there is room
  assign issue = (state == IDLE) && !ar_valid_o && (fetch.flush || (line_cnt < LINE_DEPTH));

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state      <= IDLE;
      ar_valid_o <= 1'b0;
      stale      <= 1'b0;
    end else begin
      if (issue) begin
        ar_valid_o <= 1'b1;
      end else if (ar_ready_i) begin
        ar_valid_o <= 1'b0;
      end

      case (state)
        IDLE: begin
          if (ar_valid_o && ar_ready_i) begin
            state <= WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (r_valid_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase

      // request from the old path still on the bus
      if (fetch.flush && busy && !resp_done) begin
        stale <= 1'b1;
      end else if (resp_done) begin
        stale <= 1'b0;
      end
    end
  end

  // address held until the request is taken
  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr <= fetch.flush ? pc_line : head_addr + LINE_AW'(line_cnt);
    end
  end

  assign ar_addr_o = {req_addr, {FETCH_LINE_OFFSET_BITS{1'b0}}};
  assign r_ready_o = (state == WAIT_DATA);

  assign push = resp_done && !stale && !fetch.flush;

  // ============================================================
  // line storage and word select
  // ============================================================

  sync_fifo #(
    .entry_t (line_t),
    .DEPTH   (`FETCH_LINE_DEPTH)
  ) line_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (fetch.flush),
    .push_i  (push),
    .data_i  (r_data_i),
    .pop_i   (pop),
    .data_o  (head_line),
    .empty_o (empty),
    .full_o  ()
  );

  assign fetch.inst_valid = !empty && !fetch.flush && (pc_line == head_addr);
  assign fetch.inst       = head_line[{fetch.pc[3:2], 5'b00000} +: 32];

  a_ar_stable: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("fetch_buffer: AR request changed before handshake");

endmodule

//--- logic/sync_fifo.sv
module sync_fifo #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int AW = $clog2(DEPTH);

  entry_t      mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  // pointers carry one extra wrap bit
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush_i) begin
      // drop everything stored, keep write side where it is
      rd_ptr <= wr_ptr;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr[AW-1:0]] <= data_i;
    end
  end

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // a push into an empty fifo shows up at once
  assign data_o = (empty_o && push_i) ? data_i : mem[rd_ptr[AW-1:0]];

  a_no_push_full: assert property (@(posedge clk) disable iff (rst_n)
    push_i && !flush_i |-> !full_o)
    else $error("sync_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_n)
    pop_i && !flush_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

//--- logic/fetch_if.sv
interface fetch_if;

  // current fetch address
  logic [31:0] pc;
  // redirect strobe, one cycle with the new pc
  logic        flush;
  // word at pc is available this cycle
  logic        inst_valid;
  logic [31:0] inst;

  modport seq (
    output pc,
    output flush,
    input  inst_valid,
    input  inst
  );

  modport buffer (
    input  pc,
    input  flush,
    output inst_valid,
    output inst
  );

endinterface

//--- logic/fetch_pkg.sv
package fetch_pkg;

  // ============================================================
  // line geometry
  // ============================================================

  // byte offset bits inside one 16-byte line
  localparam int FETCH_LINE_OFFSET_BITS = 4;

  // word n sits at bits 32n+31 .. 32n
  typedef logic [127:0] line_t;

  // ============================================================
  // fetch output
  // ============================================================

  // one fetched instruction and its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  // predecode result, only jal changes the flow for now
  typedef enum logic [1:0] {
    CLASS_SEQ = 2'd0,
    CLASS_JAL = 2'd1
  } inst_class_e;

endpackage

//--- logic/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// cache lines held ahead of the pc, power of two
`define FETCH_LINE_DEPTH 4

// pc/instruction packets waiting for the core
`define FETCH_QUEUE_DEPTH 4

`endif
